/* logic/shouse_params.svh */
`ifndef SHOUSE_PARAMS_SVH
`define SHOUSE_PARAMS_SVH

// cpu enable rate is num/den of the system clock
`define SHOUSE_CEN_NUM 1
`define SHOUSE_CEN_DEN 4

// frequency meter window, in clocks, as a power of two
`define SHOUSE_WIN_LOG2 10

// address bits 15:8 of the key chip page
`define SHOUSE_KEY_PAGE 8'h80

// read value when nothing answers
`define SHOUSE_OPEN_BUS 8'hff

`endif

/* logic/shouse_bus_pkg.sv */
`default_nettype none

package shouse_bus_pkg;

    // cpu side, wishbone classic, 4MB byte space
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [21:0] adr;
        logic [ 7:0] dat;   // write data
    } cpu_req_t;

    typedef struct packed {
        logic       ack;
        logic [7:0] dat;    // valid with ack
    } cpu_rsp_t;

    // memory side, bit 22 of adr picks rom (1) or ram (0)
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [22:0] adr;
        logic [ 7:0] dat;
    } mem_req_t;

    typedef struct packed {
        logic       ack;
        logic [7:0] dat;
    } mem_rsp_t;

endpackage

`default_nettype wire

/* logic/shouse_cfg_pkg.sv */
`default_nettype none

package shouse_cfg_pkg;

    // write port fed while the rom header is downloaded
    typedef struct packed {
        logic       en;     // header download active
        logic       wr;
        logic [2:0] addr;
        logic [7:0] data;
    } prog_t;

    // average cpu frequency, four bcd digits, d3 is the most significant
    typedef struct packed {
        logic [3:0] d3;
        logic [3:0] d2;
        logic [3:0] d1;
        logic [3:0] d0;
    } fave_t;

endpackage

`default_nettype wire

/* logic/shouse_cenloop.sv */
`timescale 1ns/1ps
`default_nettype none
`include "shouse_params.svh"

module shouse_cenloop(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  bus_busy,    // memory cycle open, hold enables
    input  logic [7:0]            debug_bus,
    output logic [1:0]            cpu_cen,
    output shouse_cfg_pkg::fave_t fave,
    output logic [7:0]            debug_view
);

localparam int CAP = 4 * `SHOUSE_CEN_DEN;           // at most four periods of credit
localparam int AW  = $clog2(CAP + `SHOUSE_CEN_NUM + 1);

logic [AW-1:0]               acc;
logic [AW-1:0]               sum;
logic                        fire;
logic                        half;                   // toggles on every bit 0 enable
logic [`SHOUSE_WIN_LOG2-1:0] win_cnt;
logic [15:0]                 cnt;                    // bcd enable count in this window
logic [15:0]                 cnt_nx;

// adds one to a four digit bcd value, wraps at 9999
function automatic logic [15:0] bcd_inc(input logic [15:0] v);
    logic [15:0] r;
    logic        carry;
    r     = v;
    carry = 1'b1;
    for (int i = 0; i < 4; i++) begin
        if (carry) begin
            if (r[i*4 +: 4] == 4'd9) begin
                r[i*4 +: 4] = 4'd0;                  // carry ripples up
            end else begin
                r[i*4 +: 4] = r[i*4 +: 4] + 4'd1;
                carry       = 1'b0;
            end
        end
    end
    return r;
endfunction

assign sum  = acc + AW'(`SHOUSE_CEN_NUM);
assign fire = ~bus_busy && (sum >= AW'(`SHOUSE_CEN_DEN)); // no enable during a stall

// fractional divider
// during a stall the credit keeps growing, afterwards it drains one enable per clock
always_ff @(posedge clk) begin
    if (reset) begin
        acc     <= '0;
        half    <= 1'b0;
        cpu_cen <= 2'b00;
    end else begin
        cpu_cen <= {fire & half, fire};              // bit 1 at half the rate
        if (fire) half <= ~half;
        if (bus_busy) begin
            acc <= (sum > AW'(CAP)) ? AW'(CAP) : sum; // credit capped
        end else if (fire) begin
            acc <= sum - AW'(`SHOUSE_CEN_DEN);
        end else begin
            acc <= sum;
        end
    end
end

assign cnt_nx = fire ? bcd_inc(cnt) : cnt;

// frequency meter
always_ff @(posedge clk) begin
    if (reset) begin
        win_cnt <= '0;
        cnt     <= 16'd0;
        fave    <= '0;
    end else begin
        win_cnt <= win_cnt + 1'b1;
        if (&win_cnt) begin
            fave <= shouse_cfg_pkg::fave_t'(cnt_nx); // last clock of the window counts too
            cnt  <= 16'd0;
        end else begin
            cnt  <= cnt_nx;
        end
    end
end

// debug port, average frequency in bcd
always_comb begin
    case (debug_bus)
        8'd0:    debug_view = {fave.d3, fave.d2};
        8'd1:    debug_view = {fave.d1, fave.d0};
        default: debug_view = 8'd0;
    endcase
end

endmodule

`default_nettype wire

/* logic/shouse_key.sv */
`timescale 1ns/1ps
`default_nettype none
`include "shouse_params.svh"

module shouse_key(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cs,       // one clock per access
    input  logic                  rnw,
    input  logic [2:0]            addr,
    input  logic [7:0]            din,
    output logic [7:0]            dout,
    input  shouse_cfg_pkg::prog_t prog      // rom header writes
);

logic [ 7:0] op_a;
logic [ 7:0] op_b;
logic [ 7:0] key_id;                        // per game value from the header
logic [15:0] prod;

assign prod = op_a * op_b;                  // 8x8 multiplier

always_ff @(posedge clk) begin
    if (reset) begin
        op_a   <= 8'd0;
        op_b   <= 8'd0;
        key_id <= 8'd0;
    end else begin
        if (cs && !rnw) begin
            case (addr)
                3'd0:    op_a <= din;
                3'd1:    op_b <= din;
                default: ;                  // the rest is read only
            endcase
        end
        // header byte 0 carries the id
        if (prog.en && prog.wr && prog.addr == 3'd0) key_id <= prog.data;
    end
end

// read side decodes the index alone
always_comb begin
    case (addr)
        3'd0:    dout = op_a;
        3'd1:    dout = op_b;
        3'd2:    dout = prod[15:8];         // product high byte
        3'd3:    dout = prod[ 7:0];
        3'd4:    dout = key_id;
        3'd5:    dout = op_a ^ op_b;
        default: dout = `SHOUSE_OPEN_BUS;   // 6 and 7 unused
    endcase
end

endmodule

`default_nettype wire

/* logic/shouse_bus.sv */
`timescale 1ns/1ps
`default_nettype none
`include "shouse_params.svh"

module shouse_bus(
    input  logic                     clk,
    input  logic                     reset,
    input  shouse_bus_pkg::cpu_req_t cpu_req,
    output shouse_bus_pkg::cpu_rsp_t cpu_rsp,
    output shouse_bus_pkg::mem_req_t mem_req,
    input  shouse_bus_pkg::mem_rsp_t mem_rsp,
    output logic                     key_cs,
    output logic                     key_rnw,
    output logic [2:0]               key_addr,
    output logic [7:0]               key_din,
    input  logic [7:0]               key_dout,
    output logic                     bus_busy
);

typedef enum logic [1:0] {
    ST_IDLE,    // waiting for a cpu strobe
    ST_LOCAL,   // answered here, ack high
    ST_MEM,     // memory cycle open
    ST_DONE     // memory data registered, ack high
} state_t;

state_t      state;
logic        req;
logic        is_rom;
logic        is_ram;
logic        is_key;
logic        to_mem;
logic [22:0] rom_adr;
logic [22:0] ram_adr;
logic        ack;
logic [ 7:0] rd_dat;
logic        mem_cyc;
logic        mem_we;
logic [22:0] mem_adr;
logic [ 7:0] mem_dat;

assign req    = cpu_req.cyc & cpu_req.stb & (state == ST_IDLE);   // new cycle only in idle
assign is_rom = cpu_req.adr[21];
assign is_ram = cpu_req.adr[21:15] == 7'd0;                        // 32kB work ram
assign is_key = cpu_req.adr[21:16] == 6'd0 && cpu_req.adr[15:8] == `SHOUSE_KEY_PAGE;
assign to_mem = is_ram | (is_rom & ~cpu_req.we);                   // rom writes stay here

// board wiring, two zero bits after the bank bits
// and bit 16 flips in the top bank
assign rom_adr = {1'b1, cpu_req.adr[21:19], 2'b00,
                  &cpu_req.adr[21:19] ? {~cpu_req.adr[16], cpu_req.adr[15:0]}
                                      : cpu_req.adr[16:0]};
assign ram_adr = {8'd0, cpu_req.adr[14:0]};

// key chip sees the request on the clock it is first taken
assign key_cs   = req & is_key;
assign key_rnw  = ~cpu_req.we;
assign key_addr = cpu_req.adr[2:0];
assign key_din  = cpu_req.dat;

assign bus_busy = (state == ST_MEM);     // stalls the enable loop

always_ff @(posedge clk) begin
    if (reset) begin
        state   <= ST_IDLE;
        ack     <= 1'b0;
        mem_cyc <= 1'b0;
    end else begin
        case (state)
            ST_IDLE: begin
                if (req) begin
                    if (to_mem) begin
                        state   <= ST_MEM;
                        mem_cyc <= 1'b1;     // cyc and stb together
                    end else begin
                        state   <= ST_LOCAL;
                        ack     <= 1'b1;     // key, open bus or rom write
                    end
                end
            end
            ST_MEM: begin
                if (mem_rsp.ack) begin      // any number of wait states
                    state   <= ST_DONE;
                    mem_cyc <= 1'b0;
                    ack     <= 1'b1;
                end
            end
            default: begin                  // ack was up for one clock
                state <= ST_IDLE;
                ack   <= 1'b0;
            end
        endcase
    end
end

// payload registers
always_ff @(posedge clk) begin
    if (req) begin
        mem_we  <= cpu_req.we;
        mem_adr <= is_rom ? rom_adr : ram_adr;
        mem_dat <= cpu_req.dat;
        rd_dat  <= is_key ? key_dout : `SHOUSE_OPEN_BUS;   // used by local answers
    end else if (state == ST_MEM && mem_rsp.ack) begin
        rd_dat  <= mem_rsp.dat;
    end
end

assign mem_req = '{cyc: mem_cyc, stb: mem_cyc, we: mem_we, adr: mem_adr, dat: mem_dat};
assign cpu_rsp = '{ack: ack, dat: rd_dat};

endmodule

`default_nettype wire

/* logic/shouse_game.sv */
`timescale 1ns/1ps
`default_nettype none

module shouse_game(
    input  logic                     clk,
    input  logic                     reset,
    input  shouse_bus_pkg::cpu_req_t cpu_req,     // main cpu
    output shouse_bus_pkg::cpu_rsp_t cpu_rsp,
    output shouse_bus_pkg::mem_req_t mem_req,     // rom and ram
    input  shouse_bus_pkg::mem_rsp_t mem_rsp,
    input  shouse_cfg_pkg::prog_t    prog,        // header download
    input  logic [7:0]               debug_bus,
    output logic [7:0]               debug_view,
    output logic [1:0]               cpu_cen
);

logic                  key_cs;
logic                  key_rnw;
logic [2:0]            key_addr;
logic [7:0]            key_din;
logic [7:0]            key_dout;
logic                  bus_busy;
shouse_cfg_pkg::fave_t fave;      // average frequency, also shown on debug_view

shouse_cenloop u_cen(
    .clk        ( clk        ),
    .reset      ( reset      ),
    .bus_busy   ( bus_busy   ),
    .debug_bus  ( debug_bus  ),
    .cpu_cen    ( cpu_cen    ),
    .fave       ( fave       ),
    .debug_view ( debug_view )
);

shouse_key u_key(
    .clk        ( clk        ),
    .reset      ( reset      ),
    .cs         ( key_cs     ),
    .rnw        ( key_rnw    ),
    .addr       ( key_addr   ),
    .din        ( key_din    ),
    .dout       ( key_dout   ),
    .prog       ( prog       )
);

shouse_bus u_bus(
    .clk        ( clk        ),
    .reset      ( reset      ),
    .cpu_req    ( cpu_req    ),
    .cpu_rsp    ( cpu_rsp    ),
    .mem_req    ( mem_req    ),
    .mem_rsp    ( mem_rsp    ),
    .key_cs     ( key_cs     ),
    .key_rnw    ( key_rnw    ),
    .key_addr   ( key_addr   ),
    .key_din    ( key_din    ),
    .key_dout   ( key_dout   ),
    .bus_busy   ( bus_busy   )  // memory stall into the enable loop
);

endmodule

`default_nettype wire

/* dv/shouse_game_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "shouse_params.svh"

module shouse_game_tb;

localparam int ACK_LIMIT   = 64;                     // clocks before a bus wait gives up
localparam int WIN_CLKS    = 1 << `SHOUSE_WIN_LOG2;  // one frequency window
localparam int CEN_PER_WIN = WIN_CLKS * `SHOUSE_CEN_NUM / `SHOUSE_CEN_DEN; // bit 0 enables

logic                     clk;
logic                     reset     = 1'b1;
shouse_bus_pkg::cpu_req_t cpu_req   = '0;
shouse_bus_pkg::cpu_rsp_t cpu_rsp;
shouse_bus_pkg::mem_req_t mem_req;
shouse_bus_pkg::mem_rsp_t mem_rsp   = '0;
shouse_cfg_pkg::prog_t    prog      = '0;
logic [7:0]               debug_bus = 8'd0;
logic [7:0]               debug_view;
logic [1:0]               cpu_cen;

integer      seed         = 32'h3572b097;  // wait state draws
logic [7:0]  ram [0:32767];                // work ram behind the bus
logic        mem_busy     = 1'b0;          // model is counting wait states
logic [1:0]  wait_left    = 2'd0;
logic [22:0] last_mem_adr = '0;            // address of the last acked memory cycle

shouse_game DUT(
    .clk        ( clk        ),
    .reset      ( reset      ),
    .cpu_req    ( cpu_req    ),
    .cpu_rsp    ( cpu_rsp    ),
    .mem_req    ( mem_req    ),
    .mem_rsp    ( mem_rsp    ),
    .prog       ( prog       ),
    .debug_bus  ( debug_bus  ),
    .debug_view ( debug_view ),
    .cpu_cen    ( cpu_cen    )
);

initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;                 // 8 ns period
end

task automatic fail_with(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1);
endtask

task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] want);
    if (actual !== want) begin
        $display("** Error: %s is %h, expected %h", name, actual, want);
        $display("test failed");
        $fatal(1);
    end
endtask

// rom content is the xor of the three address bytes
function automatic logic [7:0] rom_byte(input logic [22:0] a);
    return {1'b0, a[22:16]} ^ a[15:8] ^ a[7:0];
endfunction

// true when the controller answers by itself without a memory cycle
function automatic logic is_local(input logic we, input logic [21:0] adr);
    logic rom;
    logic ram_hit;
    rom     = adr[21];
    ram_hit = (adr[21:15] == 7'd0);
    return !(ram_hit || (rom && !we));
endfunction

// board wiring of rom and ram onto the memory bus
function automatic logic [22:0] expected_mem_adr(input logic [21:0] adr);
    logic [22:0] m;
    if (adr[21]) begin
        m = {1'b1, adr[21:19], 2'b00, adr[16:0]};
        if (adr[21:19] == 3'b111) m[16] = ~m[16];  // top bank flips bit 16
    end else begin
        m = {8'd0, adr[14:0]};
    end
    return m;
endfunction

// memory model with 0 to 3 wait states per cycle
always @(posedge clk) begin
    logic [1:0] draw;
    logic       go;
    go = 1'b0;
    if (reset) begin
        mem_rsp   <= '0;
        mem_busy  <= 1'b0;
        wait_left <= 2'd0;
    end else begin
        mem_rsp.ack <= 1'b0;
        if (mem_req.cyc && mem_req.stb && !mem_rsp.ack) begin  // skip the clock of our ack
            if (mem_req.we && mem_req.adr[22]) fail_with("a rom write reached the memory bus");
            if (!mem_busy) begin
                draw = 2'($random(seed));
                if (draw == 2'd0) begin
                    go = 1'b1;                 // zero wait states
                end else begin
                    mem_busy  <= 1'b1;
                    wait_left <= draw - 2'd1;
                end
            end else if (wait_left == 2'd0) begin
                go       = 1'b1;
                mem_busy <= 1'b0;
            end else begin
                wait_left <= wait_left - 2'd1;
            end
        end
        if (go) begin
            mem_rsp.ack  <= 1'b1;
            last_mem_adr <= mem_req.adr;
            if (mem_req.adr[22]) mem_rsp.dat <= rom_byte(mem_req.adr);
            else if (mem_req.we) ram[mem_req.adr[14:0]] = mem_req.dat;
            else                 mem_rsp.dat <= ram[mem_req.adr[14:0]];
        end
    end
end

task automatic header_write(input logic [2:0] addr, input logic [7:0] data);
    @(posedge clk);
    prog <= '{en: 1'b1, wr: 1'b1, addr: addr, data: data};
    @(posedge clk);
    prog <= '0;
endtask

// runs one cpu cycle and counts the sampled clocks before ack in lat
task automatic bus_cycle(input logic we, input logic [21:0] adr, input logic [7:0] dat,
                         output logic [7:0] rdata, output int lat);
    logic no_mem;
    no_mem = is_local(we, adr);
    lat    = 0;
    @(posedge clk);
    cpu_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
    @(negedge clk);
    while (!cpu_rsp.ack) begin
        if (no_mem) check_value("mem_req.cyc", 32'(mem_req.cyc), 32'd0);
        lat++;
        if (lat > ACK_LIMIT) fail_with("no ack from the bus controller within the timeout");
        @(negedge clk);
    end
    if (no_mem) check_value("mem_req.cyc", 32'(mem_req.cyc), 32'd0);
    rdata = cpu_rsp.dat;                   // valid with ack
    @(posedge clk);
    cpu_req <= '0;
    @(negedge clk);
    check_value("cpu_rsp.ack", 32'(cpu_rsp.ack), 32'd0);   // single clock ack
endtask

// enables are counted over the last window only, far from any earlier stall
task automatic freq_check(input logic [7:0] sel, input int windows, input logic [7:0] want);
    int cen0;
    int cen1;
    cen0 = 0;
    cen1 = 0;
    @(posedge clk);
    debug_bus <= sel;
    for (int i = 0; i < windows * WIN_CLKS; i++) begin   // no bus traffic meanwhile
        @(negedge clk);
        if (i >= (windows - 1) * WIN_CLKS) begin
            cen0 += int'(cpu_cen[0]);
            cen1 += int'(cpu_cen[1]);
        end
    end
    @(negedge clk);
    check_value("debug_view", 32'(debug_view), 32'(want));
    if (windows >= 2) begin
        check_value("cpu_cen[0] count", 32'(cen0), 32'(CEN_PER_WIN));
        check_value("cpu_cen[1] count", 32'(cen1), 32'(CEN_PER_WIN / 2));  // every second one
    end
endtask

task automatic run_op(input logic [7:0] op, input logic [21:0] adr, input logic [7:0] dat,
                      input logic [7:0] want);
    logic [7:0] rdata;
    int         lat;
    case (op)
        "P": header_write(adr[2:0], dat);
        "F": freq_check(adr[7:0], int'(dat), want);
        default: begin
            bus_cycle(op == "W", adr, dat, rdata, lat);
            if (is_local(op == "W", adr)) check_value("ack latency", 32'(lat), 32'd1);
            else check_value("mem_req.adr", 32'(last_mem_adr), 32'(expected_mem_adr(adr)));
            if (op == "R") check_value("cpu_rsp.dat", 32'(rdata), 32'(want));
        end
    endcase
endtask

initial begin
    integer      fd;
    integer      c;
    integer      n;
    int          ops;
    logic [7:0]  ch;
    logic [31:0] adr_f;
    logic [31:0] dat_f;
    logic [31:0] want_f;
    ops = 0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    fd = $fopen("dv/shouse_tests.txt", "r");
    if (fd == 0) fail_with("cannot open dv/shouse_tests.txt");
    c = $fgetc(fd);
    while (c != -1) begin
        ch = c[7:0];
        if (ch == "#") begin
            while (c != -1 && c[7:0] != "\n") c = $fgetc(fd);   // comment line
        end else if (ch == "P" || ch == "W" || ch == "R" || ch == "F") begin
            n = $fscanf(fd, "%h %h %h", adr_f, dat_f, want_f);
            if (n != 3) fail_with("malformed line in the test file");
            run_op(ch, adr_f[21:0], dat_f[7:0], want_f[7:0]);
            ops++;
        end else if (ch != " " && ch != "\n" && ch != "\r" && ch != "\t") begin
            fail_with("unknown opcode in the test file");
        end
        if (c != -1) c = $fgetc(fd);
    end
    $fclose(fd);
    if (ops == 0) begin
        fail_with("no operations found in the test file");
    end else begin
        $display("test passed");
        $finish;
    end
end

endmodule

`default_nettype wire

/* dv/shouse_tests.txt */
# op addr data expect, all hex; P header write, W cpu write, R cpu read, expect unused for P and W
# F checks debug_view: addr is debug_bus, data is the number of windows to wait first
R 008004 00 00
P 000000 5a 00
P 000001 33 00
R 008004 00 5a
W 008000 c3 00
W 008001 5e 00
R 008000 00 c3
R 008001 00 5e
R 008002 00 47
R 008003 00 9a
R 008005 00 9d
R 008006 00 ff
W 000010 a5 00
W 007ffe 3c 00
W 001234 e1 00
R 000010 00 a5
R 007ffe 00 3c
R 001234 00 e1
R 200000 00 60
R 212345 00 07
R 3f0010 00 68
R 3ea5c3 00 1f
R 2b0100 00 68
R 010000 00 ff
R 008100 00 ff
W 200000 77 00
F 000000 03 02
F 000001 00 56
F 000002 00 00

/* tb.f */
+incdir+logic
logic/shouse_bus_pkg.sv
logic/shouse_cfg_pkg.sv
logic/shouse_cenloop.sv
logic/shouse_key.sv
logic/shouse_bus.sv
logic/shouse_game.sv
dv/shouse_game_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# verilator build and run of the shared bus testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module shouse_game_tb -f tb.f > build.log 2>&1 \
    || { cat build.log; echo "build error"; exit 1; }

# the run log decides the result
./obj_dir/Vshouse_game_tb > sim.log 2>&1 ; cat sim.log

grep -qx "test passed" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
